// ==== logic/sq_defines.svh ====
`ifndef SQ_DEFINES_SVH
`define SQ_DEFINES_SVH

// queue geometry
`define SQ_DEPTH 8
`define SQ_IDX_W 3

// datapath widths
`define XLEN 32
`define PADDR_W 32
`define BYTES 4
`define BYTE_OFF_W 2

// axi4-lite write channel fields
`define AXIL_PROT_W 3
`define AXIL_RESP_OKAY 2'b00

`endif

// ==== logic/sq_pkg.sv ====
`include "sq_defines.svh"

package sq_pkg;

    // ring pointer, dir flips on every wrap
    typedef struct packed {
        logic dir;
        logic [`SQ_IDX_W-1:0] idx;
    } sq_ptr_t;

    // drain reads the word, forwarding picks bytes
    typedef union packed {
        logic [`XLEN-1:0] word;
        logic [`BYTES-1:0][7:0] bytes;
    } sq_data_u;

    typedef struct packed {
        logic addr_valid;
        logic data_valid;
        logic committed;
        logic [`PADDR_W-`BYTE_OFF_W-1:0] word_addr;
        logic [`BYTES-1:0] byte_mask;
        sq_data_u data;
    } sq_entry_t;

    typedef struct packed {
        logic [`SQ_IDX_W-1:0] idx;
        logic [`PADDR_W-`BYTE_OFF_W-1:0] word_addr;
        logic [`BYTES-1:0] byte_mask;
    } sq_addr_wr_t;

    // size 0 byte, 1 halfword, 2 or 3 word
    typedef struct packed {
        logic [`SQ_IDX_W-1:0] idx;
        logic [1:0] size;
        logic [`XLEN-1:0] data;
    } sq_data_wr_t;

    typedef struct packed {
        sq_ptr_t ptr;
        logic [`PADDR_W-`BYTE_OFF_W-1:0] word_addr;
    } sq_fwd_req_t;

    typedef struct packed {
        logic [`BYTES-1:0] mask;
        sq_data_u data;
        logic data_invalid;
    } sq_fwd_rsp_t;

endpackage

// ==== logic/axil_pkg.sv ====
`include "sq_defines.svh"

package axil_pkg;

    // write address channel payload
    typedef struct packed {
        logic [`PADDR_W-1:0] awaddr;
        logic [`AXIL_PROT_W-1:0] awprot;
    } axil_aw_t;

    // write data channel payload
    typedef struct packed {
        logic [`XLEN-1:0] wdata;
        logic [`BYTES-1:0] wstrb;
    } axil_w_t;

endpackage

// ==== logic/sq_fwd_select.sv ====
`timescale 1ns/1ps
`include "sq_defines.svh"

module sq_fwd_select #(
    parameter int DEPTH = 8
) (
    input  logic [DEPTH-1:0]              dir_i,
    input  logic [DEPTH-1:0][`BYTES-1:0]  mask_i,
    input  sq_pkg::sq_data_u [DEPTH-1:0]  data_i,
    input  logic [DEPTH-1:0]              data_valid_i,
    output logic [`BYTES-1:0]             dir_o,
    output logic [`BYTES-1:0]             mask_o,
    output sq_pkg::sq_data_u              data_o,
    output logic [`BYTES-1:0]             data_valid_o
);
    import sq_pkg::*;

    localparam int LO = DEPTH / 2;
    localparam int HI = DEPTH - LO;

    generate
        if (DEPTH == 1) begin : g_leaf
            assign dir_o = {`BYTES{dir_i[0]}};
            assign mask_o = mask_i[0];
            assign data_o = data_i[0];
            assign data_valid_o = {`BYTES{data_valid_i[0]}};
        end else begin : g_node
            logic [1:0][`BYTES-1:0] sub_dir;
            logic [1:0][`BYTES-1:0] sub_mask;
            logic [1:0][`BYTES-1:0] sub_dv;
            sq_data_u [1:0] sub_data;
            logic [`BYTES-1:0] take_lo;

            sq_fwd_select #(.DEPTH(LO)) u_lo (
                .dir_i        (dir_i[LO-1:0]),
                .mask_i       (mask_i[LO-1:0]),
                .data_i       (data_i[LO-1:0]),
                .data_valid_i (data_valid_i[LO-1:0]),
                .dir_o        (sub_dir[0]),
                .mask_o       (sub_mask[0]),
                .data_o       (sub_data[0]),
                .data_valid_o (sub_dv[0])
            );

            sq_fwd_select #(.DEPTH(HI)) u_hi (
                .dir_i        (dir_i[DEPTH-1:LO]),
                .mask_i       (mask_i[DEPTH-1:LO]),
                .data_i       (data_i[DEPTH-1:LO]),
                .data_valid_i (data_valid_i[DEPTH-1:LO]),
                .dir_o        (sub_dir[1]),
                .mask_o       (sub_mask[1]),
                .data_o       (sub_data[1]),
                .data_valid_o (sub_dv[1])
            );

            // lower half is younger only when it has wrapped past the upper half
            always_comb begin
                for (int b = 0; b < `BYTES; b++) begin
                    take_lo[b] = (sub_mask[0][b] && (sub_dir[0][b] ^ sub_dir[1][b]))
                                 || !sub_mask[1][b];
                    dir_o[b] = take_lo[b] ? sub_dir[0][b] : sub_dir[1][b];
                    mask_o[b] = take_lo[b] ? sub_mask[0][b] : sub_mask[1][b];
                    data_valid_o[b] = take_lo[b] ? sub_dv[0][b] : sub_dv[1][b];
                    data_o.bytes[b] = take_lo[b] ? sub_data[0].bytes[b]
                                                 : sub_data[1].bytes[b];
                end
            end
        end
    endgenerate

endmodule

// ==== logic/sq_entry_file.sv ====
`timescale 1ns/1ps
`include "sq_defines.svh"

module sq_entry_file (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              alloc_i,
    output sq_pkg::sq_ptr_t                   alloc_ptr_o,
    output logic                              full_o,
    input  logic                              addr_wr_valid_i,
    input  sq_pkg::sq_addr_wr_t               addr_wr_i,
    input  logic                              data_wr_valid_i,
    input  sq_pkg::sq_data_wr_t               data_wr_i,
    input  logic                              commit_i,
    input  logic                              retire_i,
    output logic                              head_ready_o,
    output sq_pkg::sq_entry_t                 head_entry_o,
    output sq_pkg::sq_ptr_t                   head_ptr_o,
    output sq_pkg::sq_ptr_t                   tail_ptr_o,
    output logic [`SQ_DEPTH-1:0]              valid_o,
    output sq_pkg::sq_entry_t [`SQ_DEPTH-1:0] entries_o
);
    import sq_pkg::*;

    sq_ptr_t head;
    sq_ptr_t tail;
    sq_ptr_t cmt;
    logic [`SQ_DEPTH-1:0] valid;
    sq_entry_t [`SQ_DEPTH-1:0] entries;
    sq_entry_t head_entry;
    sq_data_u wr_data;
    logic alloc_take;

    // next slot around the ring
    function automatic sq_ptr_t ptr_inc(input sq_ptr_t p);
        sq_ptr_t n;
        n = p;
        if (p.idx == `SQ_IDX_W'(`SQ_DEPTH - 1)) begin
            n.idx = '0;
            n.dir = ~p.dir;
        end else begin
            n.idx = p.idx + 1'b1;
        end
        return n;
    endfunction

    assign full_o = (tail.idx == head.idx) && (tail.dir != head.dir);
    assign alloc_take = alloc_i && !full_o;

    // replicate store data across the word
    always_comb begin
        case (data_wr_i.size)
            2'd0: wr_data.word = {`BYTES{data_wr_i.data[7:0]}};
            2'd1: wr_data.word = {(`BYTES / 2){data_wr_i.data[15:0]}};
            default: wr_data.word = data_wr_i.data;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
            cmt <= '0;
            valid <= '0;
            for (int i = 0; i < `SQ_DEPTH; i++) begin
                entries[i].addr_valid <= 1'b0;
                entries[i].data_valid <= 1'b0;
                entries[i].committed <= 1'b0;
            end
        end else begin
            if (alloc_take) begin
                valid[tail.idx] <= 1'b1;
                entries[tail.idx].addr_valid <= 1'b0;
                entries[tail.idx].data_valid <= 1'b0;
                entries[tail.idx].committed <= 1'b0;
                tail <= ptr_inc(tail);
            end
            if (addr_wr_valid_i) begin
                entries[addr_wr_i.idx].word_addr <= addr_wr_i.word_addr;
                entries[addr_wr_i.idx].byte_mask <= addr_wr_i.byte_mask;
                entries[addr_wr_i.idx].addr_valid <= 1'b1;
            end
            if (data_wr_valid_i) begin
                entries[data_wr_i.idx].data <= wr_data;
                entries[data_wr_i.idx].data_valid <= 1'b1;
            end
            // commits arrive in program order
            if (commit_i) begin
                entries[cmt.idx].committed <= 1'b1;
                cmt <= ptr_inc(cmt);
            end
            if (retire_i) begin
                valid[head.idx] <= 1'b0;
                head <= ptr_inc(head);
            end
        end
    end

    assign head_entry = entries[head.idx];
    assign head_ready_o = valid[head.idx] && head_entry.addr_valid
                          && head_entry.data_valid && head_entry.committed;

    assign head_entry_o = head_entry;
    assign alloc_ptr_o = tail;
    assign head_ptr_o = head;
    assign tail_ptr_o = tail;
    assign valid_o = valid;
    assign entries_o = entries;

endmodule

// ==== logic/sq_drain_axil.sv ====
`timescale 1ns/1ps
`include "sq_defines.svh"

module sq_drain_axil (
    input  logic               clk,
    input  logic               rst,
    input  logic               head_ready_i,
    input  sq_pkg::sq_entry_t  head_entry_i,
    output logic               retire_o,
    output logic               awvalid_o,
    output axil_pkg::axil_aw_t aw_o,
    input  logic               awready_i,
    output logic               wvalid_o,
    output axil_pkg::axil_w_t  w_o,
    input  logic               wready_i,
    input  logic               bvalid_i,
    input  logic [1:0]         bresp_i,
    output logic               bready_o
);
    import axil_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        SEND,
        WAIT_B
    } drain_state_e;

    drain_state_e state;
    axil_aw_t aw_next;
    axil_w_t w_next;
    logic aw_pend;
    logic w_pend;

    assign aw_next.awaddr = {head_entry_i.word_addr, {`BYTE_OFF_W{1'b0}}};
    assign aw_next.awprot = '0;
    assign w_next.wdata = head_entry_i.data.word;
    assign w_next.wstrb = head_entry_i.byte_mask;

    // still waiting on a channel handshake
    assign aw_pend = awvalid_o && !awready_i;
    assign w_pend = wvalid_o && !wready_i;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
            awvalid_o <= 1'b0;
            wvalid_o <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (head_ready_i) begin
                        awvalid_o <= 1'b1;
                        wvalid_o <= 1'b1;
                        state <= SEND;
                    end
                end
                SEND: begin
                    awvalid_o <= aw_pend;
                    wvalid_o <= w_pend;
                    if (!aw_pend && !w_pend) begin
                        state <= WAIT_B;
                    end
                end
                WAIT_B: begin
                    if (bvalid_i) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // payload captured once per store
    always_ff @(posedge clk) begin
        if (state == IDLE && head_ready_i) begin
            aw_o <= aw_next;
            w_o <= w_next;
        end
    end

    // slave errors still free the entry
    assign retire_o = (state == WAIT_B) && bvalid_i;
    assign bready_o = 1'b1;

endmodule

// ==== logic/sq_forward.sv ====
`timescale 1ns/1ps
`include "sq_defines.svh"

module sq_forward (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              fwd_req_valid_i,
    input  sq_pkg::sq_fwd_req_t               fwd_req_i,
    input  sq_pkg::sq_ptr_t                   head_ptr_i,
    input  sq_pkg::sq_ptr_t                   tail_ptr_i,
    input  logic [`SQ_DEPTH-1:0]              valid_i,
    input  sq_pkg::sq_entry_t [`SQ_DEPTH-1:0] entries_i,
    output logic                              fwd_rsp_valid_o,
    output sq_pkg::sq_fwd_rsp_t               fwd_rsp_o
);
    import sq_pkg::*;

    sq_ptr_t load_ptr;
    logic [`SQ_DEPTH-1:0] head_mask;
    logic [`SQ_DEPTH-1:0] tail_mask;
    logic [`SQ_DEPTH-1:0] load_mask;
    logic [`SQ_DEPTH-1:0] entry_dir;
    logic [`SQ_DEPTH-1:0] span_window;
    logic [`SQ_DEPTH-1:0] full_window;
    logic [`SQ_DEPTH-1:0] window;
    logic beyond_tail;

    logic s1_valid;
    logic [`SQ_DEPTH-1:0] s1_window;
    logic [`SQ_DEPTH-1:0] s1_dir;
    logic [`PADDR_W-`BYTE_OFF_W-1:0] s1_word_addr;

    logic [`SQ_DEPTH-1:0] hit;
    logic [`SQ_DEPTH-1:0][`BYTES-1:0] hit_mask;
    sq_data_u [`SQ_DEPTH-1:0] cand_data;
    logic [`SQ_DEPTH-1:0] cand_dv;
    logic [`BYTES-1:0] sel_mask;
    logic [`BYTES-1:0] sel_dv;
    sq_data_u sel_data;

    assign load_ptr = fwd_req_i.ptr;

    // thermometer masks, bit j set when j is below the pointer index
    always_comb begin
        for (int j = 0; j < `SQ_DEPTH; j++) begin
            head_mask[j] = `SQ_IDX_W'(j) < head_ptr_i.idx;
            tail_mask[j] = `SQ_IDX_W'(j) < tail_ptr_i.idx;
            load_mask[j] = `SQ_IDX_W'(j) < load_ptr.idx;
            entry_dir[j] = (`SQ_IDX_W'(j) >= head_ptr_i.idx) ? head_ptr_i.dir
                                                              : ~head_ptr_i.dir;
        end
    end

    assign beyond_tail = (load_ptr.dir == tail_ptr_i.dir) ? (load_ptr.idx > tail_ptr_i.idx)
                                                          : (load_ptr.idx < tail_ptr_i.idx);
    assign span_window = {`SQ_DEPTH{head_ptr_i.dir ^ load_ptr.dir}} ^ (head_mask ^ load_mask);
    assign full_window = {`SQ_DEPTH{head_ptr_i.dir ^ tail_ptr_i.dir}} ^ (head_mask ^ tail_mask);
    assign window = (beyond_tail ? full_window : span_window) & valid_i;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1_valid <= 1'b0;
            fwd_rsp_valid_o <= 1'b0;
        end else begin
            s1_valid <= fwd_req_valid_i;
            fwd_rsp_valid_o <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_window <= window;
        s1_dir <= entry_dir;
        s1_word_addr <= fwd_req_i.word_addr;
    end

    // stage 2 word match, spread over each store's bytes
    always_comb begin
        for (int j = 0; j < `SQ_DEPTH; j++) begin
            hit[j] = s1_window[j] && entries_i[j].addr_valid
                     && (entries_i[j].word_addr == s1_word_addr);
            hit_mask[j] = {`BYTES{hit[j]}} & entries_i[j].byte_mask;
            cand_data[j] = entries_i[j].data;
            cand_dv[j] = entries_i[j].data_valid;
        end
    end

    sq_fwd_select #(.DEPTH(`SQ_DEPTH)) u_select (
        .dir_i        (s1_dir),
        .mask_i       (hit_mask),
        .data_i       (cand_data),
        .data_valid_i (cand_dv),
        .dir_o        (),
        .mask_o       (sel_mask),
        .data_o       (sel_data),
        .data_valid_o (sel_dv)
    );

    always_ff @(posedge clk) begin
        fwd_rsp_o.mask <= sel_mask;
        fwd_rsp_o.data <= sel_data;
        fwd_rsp_o.data_invalid <= |(sel_mask & ~sel_dv);
    end

endmodule

// ==== logic/store_queue.sv ====
`timescale 1ns/1ps
`include "sq_defines.svh"

module store_queue (
    input  logic                clk,
    input  logic                rst,
    input  logic                alloc_i,
    output sq_pkg::sq_ptr_t     alloc_ptr_o,
    output logic                full_o,
    input  logic                addr_wr_valid_i,
    input  sq_pkg::sq_addr_wr_t addr_wr_i,
    input  logic                data_wr_valid_i,
    input  sq_pkg::sq_data_wr_t data_wr_i,
    input  logic                commit_i,
    input  logic                fwd_req_valid_i,
    input  sq_pkg::sq_fwd_req_t fwd_req_i,
    output logic                fwd_rsp_valid_o,
    output sq_pkg::sq_fwd_rsp_t fwd_rsp_o,
    output logic                awvalid_o,
    output axil_pkg::axil_aw_t  aw_o,
    input  logic                awready_i,
    output logic                wvalid_o,
    output axil_pkg::axil_w_t   w_o,
    input  logic                wready_i,
    input  logic                bvalid_i,
    input  logic [1:0]          bresp_i,
    output logic                bready_o
);
    import sq_pkg::*;

    sq_entry_t head_entry;
    sq_entry_t [`SQ_DEPTH-1:0] entries;
    sq_ptr_t head_ptr;
    sq_ptr_t tail_ptr;
    logic [`SQ_DEPTH-1:0] valid;
    logic head_ready;
    logic retire;

    sq_entry_file u_entry_file (
        .clk             (clk),
        .rst             (rst),
        .alloc_i         (alloc_i),
        .alloc_ptr_o     (alloc_ptr_o),
        .full_o          (full_o),
        .addr_wr_valid_i (addr_wr_valid_i),
        .addr_wr_i       (addr_wr_i),
        .data_wr_valid_i (data_wr_valid_i),
        .data_wr_i       (data_wr_i),
        .commit_i        (commit_i),
        .retire_i        (retire),
        .head_ready_o    (head_ready),
        .head_entry_o    (head_entry),
        .head_ptr_o      (head_ptr),
        .tail_ptr_o      (tail_ptr),
        .valid_o         (valid),
        .entries_o       (entries)
    );

    sq_drain_axil u_drain (
        .clk          (clk),
        .rst          (rst),
        .head_ready_i (head_ready),
        .head_entry_i (head_entry),
        .retire_o     (retire),
        .awvalid_o    (awvalid_o),
        .aw_o         (aw_o),
        .awready_i    (awready_i),
        .wvalid_o     (wvalid_o),
        .w_o          (w_o),
        .wready_i     (wready_i),
        .bvalid_i     (bvalid_i),
        .bresp_i      (bresp_i),
        .bready_o     (bready_o)
    );

    sq_forward u_forward (
        .clk             (clk),
        .rst             (rst),
        .fwd_req_valid_i (fwd_req_valid_i),
        .fwd_req_i       (fwd_req_i),
        .head_ptr_i      (head_ptr),
        .tail_ptr_i      (tail_ptr),
        .valid_i         (valid),
        .entries_i       (entries),
        .fwd_rsp_valid_o (fwd_rsp_valid_o),
        .fwd_rsp_o       (fwd_rsp_o)
    );

endmodule

// ==== tests/sq_axil_mem.sv ====
`timescale 1ns/1ps
`include "sq_defines.svh"

module sq_axil_mem (
    input  logic               clk,
    input  logic               rst,
    input  logic               awvalid_i,
    input  axil_pkg::axil_aw_t aw_i,
    output logic               awready_o,
    input  logic               wvalid_i,
    input  axil_pkg::axil_w_t  w_i,
    output logic               wready_o,
    output logic               bvalid_o,
    output logic [1:0]         bresp_o,
    input  logic               bready_i
);
    import axil_pkg::*;

    logic [1:0] aw_wait;
    logic [1:0] w_wait;
    logic aw_got;
    logic w_got;
    logic [31:0] addr_q;
    axil_w_t w_q;

    // one record per completed write
    logic [31:0] log_addr [16];
    logic [3:0] log_strb [16];
    logic [31:0] log_data [16];
    int log_count;

    assign bresp_o = `AXIL_RESP_OKAY;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            awready_o <= 1'b0;
            wready_o <= 1'b0;
            aw_wait <= '0;
            w_wait <= '0;
            aw_got <= 1'b0;
            w_got <= 1'b0;
            bvalid_o <= 1'b0;
            log_count <= 0;
        end else begin
            awready_o <= 1'b0;
            wready_o <= 1'b0;
            if (awvalid_i && awready_o) begin
                aw_got <= 1'b1;
                addr_q <= aw_i.awaddr;
                aw_wait <= 2'($urandom % 4);
            end else if (awvalid_i && !aw_got) begin
                if (aw_wait == 2'd0) awready_o <= 1'b1;
                else aw_wait <= aw_wait - 2'd1;
            end
            if (wvalid_i && wready_o) begin
                w_got <= 1'b1;
                w_q <= w_i;
                w_wait <= 2'($urandom % 4);
            end else if (wvalid_i && !w_got) begin
                if (w_wait == 2'd0) wready_o <= 1'b1;
                else w_wait <= w_wait - 2'd1;
            end
            // response once both halves are in
            if (bvalid_o && bready_i) begin
                bvalid_o <= 1'b0;
            end else if (aw_got && w_got && !bvalid_o) begin
                bvalid_o <= 1'b1;
                aw_got <= 1'b0;
                w_got <= 1'b0;
                log_addr[log_count[3:0]] <= addr_q;
                log_strb[log_count[3:0]] <= w_q.wstrb;
                log_data[log_count[3:0]] <= w_q.wdata;
                log_count <= log_count + 1;
            end
        end
    end

endmodule

// ==== tests/tb_store_queue.sv ====
`timescale 1ns/1ps

module tb_store_queue;
    import sq_pkg::*;
    import axil_pkg::*;

    typedef enum {OP_ALLOC, OP_ADDR, OP_DATA, OP_COMMIT, OP_FWD, OP_WAIT} op_e;

    // arg is ptr/idx/log slot, bits is mask or size, flag is full or data_invalid
    typedef struct {
        op_e op;
        logic [3:0] arg;
        logic [29:0] waddr;
        logic [3:0] bits;
        logic [31:0] data;
        logic flag;
    } step_t;

    localparam logic [29:0] WA = 30'h100;
    localparam logic [29:0] WB = 30'h200;
    localparam logic [29:0] WC = 30'h300;

    logic clk;
    logic rst;
    logic alloc_i;
    sq_ptr_t alloc_ptr;
    logic full;
    logic addr_wr_valid;
    sq_addr_wr_t addr_wr;
    logic data_wr_valid;
    sq_data_wr_t data_wr;
    logic commit;
    logic fwd_req_valid;
    sq_fwd_req_t fwd_req;
    logic fwd_rsp_valid;
    sq_fwd_rsp_t fwd_rsp;
    logic awvalid;
    axil_aw_t aw;
    logic awready;
    logic wvalid;
    axil_w_t w;
    logic wready;
    logic bvalid;
    logic [1:0] bresp;
    logic bready;

    step_t steps[$];
    step_t s;
    int cycles;
    int drains;

    store_queue store_queue_i (
        .clk(clk), .rst(rst), .alloc_i(alloc_i), .alloc_ptr_o(alloc_ptr), .full_o(full),
        .addr_wr_valid_i(addr_wr_valid), .addr_wr_i(addr_wr),
        .data_wr_valid_i(data_wr_valid), .data_wr_i(data_wr), .commit_i(commit),
        .fwd_req_valid_i(fwd_req_valid), .fwd_req_i(fwd_req),
        .fwd_rsp_valid_o(fwd_rsp_valid), .fwd_rsp_o(fwd_rsp),
        .awvalid_o(awvalid), .aw_o(aw), .awready_i(awready),
        .wvalid_o(wvalid), .w_o(w), .wready_i(wready),
        .bvalid_i(bvalid), .bresp_i(bresp), .bready_o(bready)
    );

    sq_axil_mem mem_i (
        .clk(clk), .rst(rst), .awvalid_i(awvalid), .aw_i(aw), .awready_o(awready),
        .wvalid_i(wvalid), .w_i(w), .wready_o(wready),
        .bvalid_o(bvalid), .bresp_o(bresp), .bready_i(bready)
    );

    function automatic step_t mk(op_e op, logic [3:0] arg, logic [29:0] waddr,
                                 logic [3:0] bits, logic [31:0] data, logic flag);
        step_t t;
        t.op = op;
        t.arg = arg;
        t.waddr = waddr;
        t.bits = bits;
        t.data = data;
        t.flag = flag;
        return t;
    endfunction

    function automatic logic [31:0] lane_bits(logic [3:0] m);
        return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
    endfunction

    task automatic check(string what, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("TESTBENCH FAILED");
            $fatal(1, "mismatch");
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > 40 * steps.size()) begin
            $display("TESTBENCH FAILED");
            $fatal(1, "timeout: the run took longer than the step table allows");
        end
    end

    initial begin
        void'($urandom(32'h0cd9_88e4));
        for (int i = 0; i < 8; i++) begin
            steps.push_back(mk(OP_ALLOC, 4'(i), 30'h0, 4'h0, 32'h0, 1'b0));
        end
        steps.push_back(mk(OP_ALLOC, 4'h8, 30'h0, 4'h0, 32'h0, 1'b1));
        steps.push_back(mk(OP_ADDR, 4'h0, WA, 4'hf, 32'h0, 1'b0));
        steps.push_back(mk(OP_ADDR, 4'h1, WA, 4'h3, 32'h0, 1'b0));
        steps.push_back(mk(OP_ADDR, 4'h2, WB, 4'h4, 32'h0, 1'b0));
        steps.push_back(mk(OP_ADDR, 4'h3, WA, 4'h1, 32'h0, 1'b0));
        steps.push_back(mk(OP_ADDR, 4'h4, WA, 4'hf, 32'h0, 1'b0));
        steps.push_back(mk(OP_ADDR, 4'h5, WC, 4'hf, 32'h0, 1'b0));
        steps.push_back(mk(OP_ADDR, 4'h6, WC, 4'hc, 32'h0, 1'b0));
        steps.push_back(mk(OP_ADDR, 4'h7, WC, 4'hf, 32'h0, 1'b0));
        steps.push_back(mk(OP_DATA, 4'h0, 30'h0, 4'h2, 32'h1122_3344, 1'b0));
        steps.push_back(mk(OP_DATA, 4'h1, 30'h0, 4'h1, 32'h0000_beef, 1'b0));
        steps.push_back(mk(OP_DATA, 4'h2, 30'h0, 4'h0, 32'h0000_005a, 1'b0));
        steps.push_back(mk(OP_DATA, 4'h4, 30'h0, 4'h2, 32'hcafe_f00d, 1'b0));
        steps.push_back(mk(OP_DATA, 4'h5, 30'h0, 4'h3, 32'h55aa_55aa, 1'b0));
        steps.push_back(mk(OP_DATA, 4'h6, 30'h0, 4'h1, 32'h0000_1234, 1'b0));
        steps.push_back(mk(OP_DATA, 4'h7, 30'h0, 4'h2, 32'hdead_beef, 1'b0));
        // forwarding against a full queue with nothing committed
        steps.push_back(mk(OP_FWD, 4'h2, WA, 4'hf, 32'h1122_beef, 1'b0));
        steps.push_back(mk(OP_FWD, 4'h4, WA, 4'hf, 32'h0, 1'b1));
        steps.push_back(mk(OP_FWD, 4'h4, WB, 4'h4, 32'h005a_0000, 1'b0));
        steps.push_back(mk(OP_FWD, 4'h2, WB, 4'h0, 32'h0, 1'b0));
        steps.push_back(mk(OP_DATA, 4'h3, 30'h0, 4'h0, 32'h0000_0077, 1'b0));
        steps.push_back(mk(OP_FWD, 4'h4, WA, 4'hf, 32'h1122_be77, 1'b0));
        steps.push_back(mk(OP_FWD, 4'h6, WA, 4'hf, 32'hcafe_f00d, 1'b0));
        // one retire frees a slot for a wrapped allocation
        steps.push_back(mk(OP_COMMIT, 4'h0, 30'h0, 4'h0, 32'h0, 1'b0));
        steps.push_back(mk(OP_WAIT, 4'h0, WA, 4'hf, 32'h1122_3344, 1'b0));
        steps.push_back(mk(OP_ALLOC, 4'h8, 30'h0, 4'h0, 32'h0, 1'b0));
        steps.push_back(mk(OP_ALLOC, 4'h9, 30'h0, 4'h0, 32'h0, 1'b1));
        steps.push_back(mk(OP_ADDR, 4'h0, WA, 4'h8, 32'h0, 1'b0));
        steps.push_back(mk(OP_DATA, 4'h0, 30'h0, 4'h0, 32'h0000_0099, 1'b0));
        steps.push_back(mk(OP_FWD, 4'h9, WA, 4'hf, 32'h99fe_f00d, 1'b0));
        for (int i = 0; i < 6; i++) begin
            steps.push_back(mk(OP_COMMIT, 4'h0, 30'h0, 4'h0, 32'h0, 1'b0));
        end
        steps.push_back(mk(OP_WAIT, 4'h1, WA, 4'h3, 32'hbeef_beef, 1'b0));
        steps.push_back(mk(OP_WAIT, 4'h2, WB, 4'h4, 32'h5a5a_5a5a, 1'b0));
        steps.push_back(mk(OP_WAIT, 4'h3, WA, 4'h1, 32'h7777_7777, 1'b0));
        steps.push_back(mk(OP_WAIT, 4'h4, WA, 4'hf, 32'hcafe_f00d, 1'b0));
        steps.push_back(mk(OP_WAIT, 4'h5, WC, 4'hf, 32'h55aa_55aa, 1'b0));
        steps.push_back(mk(OP_WAIT, 4'h6, WC, 4'hc, 32'h1234_1234, 1'b0));

        rst = 1'b1;
        alloc_i = 1'b0;
        addr_wr_valid = 1'b0;
        addr_wr = '0;
        data_wr_valid = 1'b0;
        data_wr = '0;
        commit = 1'b0;
        fwd_req_valid = 1'b0;
        fwd_req = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check("full after reset", 32'(full), 32'h0);
        check("awvalid after reset", 32'(awvalid), 32'h0);
        check("wvalid after reset", 32'(wvalid), 32'h0);
        check("fwd valid after reset", 32'(fwd_rsp_valid), 32'h0);
        check("alloc ptr after reset", 32'(alloc_ptr), 32'h0);
        check("bready after reset", 32'(bready), 32'h1);

        drains = 0;
        foreach (steps[i]) begin
            s = steps[i];
            case (s.op)
                OP_ALLOC: begin
                    check("alloc ptr", 32'(alloc_ptr), 32'(s.arg));
                    check("full", 32'(full), 32'(s.flag));
                    alloc_i = 1'b1;
                    @(negedge clk);
                    alloc_i = 1'b0;
                end
                OP_ADDR: begin
                    addr_wr.idx = s.arg[2:0];
                    addr_wr.word_addr = s.waddr;
                    addr_wr.byte_mask = s.bits;
                    addr_wr_valid = 1'b1;
                    @(negedge clk);
                    addr_wr_valid = 1'b0;
                end
                OP_DATA: begin
                    data_wr.idx = s.arg[2:0];
                    data_wr.size = s.bits[1:0];
                    data_wr.data = s.data;
                    data_wr_valid = 1'b1;
                    @(negedge clk);
                    data_wr_valid = 1'b0;
                end
                OP_COMMIT: begin
                    commit = 1'b1;
                    @(negedge clk);
                    commit = 1'b0;
                end
                OP_FWD: begin
                    fwd_req.ptr = s.arg;
                    fwd_req.word_addr = s.waddr;
                    fwd_req_valid = 1'b1;
                    @(negedge clk);
                    fwd_req_valid = 1'b0;
                    check("fwd valid early", 32'(fwd_rsp_valid), 32'h0);
                    @(negedge clk);
                    check("fwd valid", 32'(fwd_rsp_valid), 32'h1);
                    check("fwd mask", 32'(fwd_rsp.mask), 32'(s.bits));
                    check("fwd data_invalid", 32'(fwd_rsp.data_invalid), 32'(s.flag));
                    if (!s.flag) begin
                        check("fwd data", fwd_rsp.data.word & lane_bits(s.bits), s.data);
                    end
                end
                OP_WAIT: begin
                    while (mem_i.log_count <= int'(s.arg)) @(negedge clk);
                    // head advances on the edge after the logged write
                    @(negedge clk);
                    check("drain addr", mem_i.log_addr[s.arg], {s.waddr, 2'b00});
                    check("drain strb", 32'(mem_i.log_strb[s.arg]), 32'(s.bits));
                    check("drain data", mem_i.log_data[s.arg], s.data);
                    drains++;
                end
                default: ;
            endcase
        end

        // uncommitted stores must stay put
        repeat (40) @(negedge clk);
        check("write count", 32'(mem_i.log_count), 32'(drains));
        check("awvalid idle", 32'(awvalid), 32'h0);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+logic
logic/sq_pkg.sv
logic/axil_pkg.sv
logic/sq_fwd_select.sv
logic/sq_entry_file.sv
logic/sq_drain_axil.sv
logic/sq_forward.sv
logic/store_queue.sv
tests/sq_axil_mem.sv
tests/tb_store_queue.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_store_queue
FLIST ?= sources.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing -j 0
PASS_TEXT ?= TESTBENCH PASSED

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(SIM_BIN) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
